/* Bender.yml */
package:
  name: pi1_dcache

sources:
  # Design, package first.
  - logic/pi1_dcache_pkg.sv
  - logic/pi1_write_buffer.sv
  - logic/pi1_cache_store.sv
  - logic/pi1_miss_control.sv
  - logic/pi1_dcache.sv
  # Testbench with the bound port properties.
  - target: test
    files:
      - tb/pi1_dcache_properties.sv
      - tb/tb_pi1_dcache.sv

/* logic/pi1_cache_store.sv */
// PI1 data cache line storage.
// Direct mapped tag, data and valid arrays with a registered lookup, the
// hit compare, the byte merge of write hits, a one-entry bypass for a
// lookup right behind a merge, and the valid sweep run on reset or flush.

`timescale 1ns/10ps

module pi1_cache_store #(
	parameter int SET_COUNT = 8
) (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  crst_i,
	input  logic                  lookup_i,
	input  pi1_dcache_pkg::addr_t lookup_addr_i,
	input  pi1_dcache_pkg::addr_t hold_addr_i,
	input  pi1_dcache_pkg::sel_t  hold_sel_i,
	input  pi1_dcache_pkg::word_t hold_data_i,
	input  logic                  write_hit_i,
	input  logic                  fill_i,
	input  pi1_dcache_pkg::word_t fill_data_i,
	output logic                  hit_o,
	output pi1_dcache_pkg::word_t rd_data_o,
	output logic                  sweeping_o
);

	localparam int IDX_BITS = $clog2(SET_COUNT);
	localparam int TAG_BITS = pi1_dcache_pkg::ADDR_BITS - IDX_BITS;

	typedef logic [IDX_BITS-1:0] idx_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	tag_t                  tag_mem  [SET_COUNT];
	pi1_dcache_pkg::word_t data_mem [SET_COUNT];
	logic [SET_COUNT-1:0]  valid_q;

	tag_t                  tag_rd_q;
	pi1_dcache_pkg::word_t data_rd_q;
	logic                  valid_rd_q;
	logic                  byp_valid_q;
	pi1_dcache_pkg::addr_t byp_addr_q;
	pi1_dcache_pkg::word_t byp_data_q;
	logic                  sweep_q;
	idx_t                  sweep_idx_q;

	idx_t                  lookup_idx;
	idx_t                  hold_idx;
	tag_t                  hold_tag;
	logic                  byp_hit;
	pi1_dcache_pkg::word_t cur_word;
	pi1_dcache_pkg::word_t sel_mask;
	pi1_dcache_pkg::word_t merged_word;

	assign lookup_idx = lookup_addr_i[IDX_BITS-1:0];
	assign hold_idx   = hold_addr_i[IDX_BITS-1:0];
	assign hold_tag   = hold_addr_i[pi1_dcache_pkg::ADDR_BITS-1:IDX_BITS];

	// The array read lags a merge on the same edge, so the merged word wins.
	assign byp_hit   = byp_valid_q && (byp_addr_q == hold_addr_i);
	assign cur_word  = byp_hit ? byp_data_q : data_rd_q;
	assign hit_o     = byp_hit || (valid_rd_q && (tag_rd_q == hold_tag));
	assign rd_data_o = cur_word;

	// A flush request already holds off the master in its first cycle.
	assign sweeping_o = sweep_q || crst_i;

	always_comb begin
		for (int b = 0; b < pi1_dcache_pkg::SEL_BITS; b++)
			sel_mask[8*b +: 8] = {8{hold_sel_i[b]}};
	end

	assign merged_word = (hold_data_i & sel_mask) | (cur_word & ~sel_mask);

	always_ff @(posedge clk_i) begin
		if (lookup_i) begin
			tag_rd_q   <= tag_mem[lookup_idx];
			data_rd_q  <= data_mem[lookup_idx];
			valid_rd_q <= valid_q[lookup_idx];
		end
		if (fill_i) begin
			tag_mem[hold_idx]  <= hold_tag;
			data_mem[hold_idx] <= fill_data_i;
		end else if (write_hit_i) begin
			data_mem[hold_idx] <= merged_word;
		end
		if (write_hit_i) begin
			byp_addr_q <= hold_addr_i;
			byp_data_q <= merged_word;
		end
	end

	// Only a lookup taken on the merge edge can have read the stale word.
	always_ff @(posedge clk_i) begin
		if (rst_i || crst_i)
			byp_valid_q <= 1'b0;
		else
			byp_valid_q <= write_hit_i && lookup_i;
	end

	// Sweep from the top set down to set 0, one set per cycle.
	always_ff @(posedge clk_i) begin
		if (fill_i)
			valid_q[hold_idx] <= 1'b1;
		if (rst_i || crst_i) begin
			sweep_q     <= 1'b1;
			sweep_idx_q <= idx_t'(SET_COUNT - 1);
		end else if (sweep_q) begin
			valid_q[sweep_idx_q] <= 1'b0;
			if (sweep_idx_q == '0)
				sweep_q <= 1'b0;
			else
				sweep_idx_q <= sweep_idx_q - 1'b1;
		end
	end

endmodule

/* logic/pi1_dcache.sv */
// PI1 write-through data cache.
// Direct mapped cache between a PI1 master and a PI1 slave memory. Read
// misses fetch whole words, writes pass through a buffer to the slave.

`timescale 1ns/10ps

module pi1_dcache #(
	parameter int SET_COUNT = 8,
	parameter int BUF_DEPTH = 4
) (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    crst_i,
	input  pi1_dcache_pkg::pi1_op_e m_op_i,
	input  pi1_dcache_pkg::addr_t   m_addr_i,
	input  pi1_dcache_pkg::word_t   m_data_i,
	input  pi1_dcache_pkg::sel_t    m_sel_i,
	output pi1_dcache_pkg::word_t   m_data_o,
	output logic                    m_rdy_o,
	output pi1_dcache_pkg::pi1_op_e s_op_o,
	output pi1_dcache_pkg::addr_t   s_addr_o,
	output pi1_dcache_pkg::word_t   s_data_o,
	output pi1_dcache_pkg::sel_t    s_sel_o,
	input  pi1_dcache_pkg::word_t   s_data_i,
	input  logic                    s_rdy_i
);

	logic                  hit;
	logic                  sweeping;
	logic                  lookup;
	logic                  write_hit;
	logic                  fill;
	logic                  buf_push;
	logic                  buf_pop;
	logic                  buf_empty;
	logic                  buf_full;
	pi1_dcache_pkg::word_t rd_data;
	pi1_dcache_pkg::word_t fill_data;
	pi1_dcache_pkg::addr_t hold_addr;
	pi1_dcache_pkg::sel_t  hold_sel;
	pi1_dcache_pkg::word_t hold_data;
	pi1_dcache_pkg::addr_t buf_addr;
	pi1_dcache_pkg::word_t buf_data;
	pi1_dcache_pkg::sel_t  buf_sel;

	pi1_miss_control #(
		.SET_COUNT (SET_COUNT),
		.BUF_DEPTH (BUF_DEPTH)
	) u_miss_control (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.m_op_i      (m_op_i),
		.m_addr_i    (m_addr_i),
		.m_data_i    (m_data_i),
		.m_sel_i     (m_sel_i),
		.m_rdy_o     (m_rdy_o),
		.m_data_o    (m_data_o),
		.hit_i       (hit),
		.rd_data_i   (rd_data),
		.sweeping_i  (sweeping),
		.hold_addr_o (hold_addr),
		.hold_sel_o  (hold_sel),
		.hold_data_o (hold_data),
		.lookup_o    (lookup),
		.write_hit_o (write_hit),
		.fill_o      (fill),
		.fill_data_o (fill_data),
		.buf_push_o  (buf_push),
		.buf_pop_o   (buf_pop),
		.buf_addr_i  (buf_addr),
		.buf_data_i  (buf_data),
		.buf_sel_i   (buf_sel),
		.buf_empty_i (buf_empty),
		.buf_full_i  (buf_full),
		.s_op_o      (s_op_o),
		.s_addr_o    (s_addr_o),
		.s_data_o    (s_data_o),
		.s_sel_o     (s_sel_o),
		.s_data_i    (s_data_i),
		.s_rdy_i     (s_rdy_i)
	);

	// The lookup index comes straight from the master address.
	pi1_cache_store #(
		.SET_COUNT (SET_COUNT)
	) u_cache_store (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.crst_i        (crst_i),
		.lookup_i      (lookup),
		.lookup_addr_i (m_addr_i),
		.hold_addr_i   (hold_addr),
		.hold_sel_i    (hold_sel),
		.hold_data_i   (hold_data),
		.write_hit_i   (write_hit),
		.fill_i        (fill),
		.fill_data_i   (fill_data),
		.hit_o         (hit),
		.rd_data_o     (rd_data),
		.sweeping_o    (sweeping)
	);

	// Write entries are taken from the master bus on the acceptance edge.
	pi1_write_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) u_write_buffer (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.push_i  (buf_push),
		.addr_i  (m_addr_i),
		.data_i  (m_data_i),
		.sel_i   (m_sel_i),
		.pop_i   (buf_pop),
		.addr_o  (buf_addr),
		.data_o  (buf_data),
		.sel_o   (buf_sel),
		.empty_o (buf_empty),
		.full_o  (buf_full)
	);

endmodule

/* logic/pi1_dcache_pkg.sv */
// PI1 data cache shared definitions.
// Word, address and select widths of the PI1 bus, the vector types built
// from them and the operation codes seen on the master and slave sides.

package pi1_dcache_pkg;

	// Width of one data word in bits.
	localparam int ARCH_BITS = 32;

	// One select bit per byte of the data word.
	localparam int SEL_BITS = ARCH_BITS / 8;

	// Addresses count words, so the byte offset bits are dropped.
	localparam int ADDR_BITS = ARCH_BITS - $clog2(SEL_BITS);

	// A full data word as carried on either bus.
	typedef logic [ARCH_BITS-1:0] word_t;

	// A word address.
	typedef logic [ADDR_BITS-1:0] addr_t;

	// Byte selects, bit n enables byte n of the word.
	typedef logic [SEL_BITS-1:0] sel_t;

	// PI1 operation codes.
	// The code 2'b11 is reserved and is never issued by a master.
	typedef enum logic [1:0] {
		OP_NOOP = 2'b00,
		OP_WR   = 2'b01,
		OP_RD   = 2'b10
	} pi1_op_e;

endpackage

/* logic/pi1_miss_control.sv */
// PI1 data cache control.
// Accepts master operations, pushes writes into the write buffer, drains
// that buffer onto the slave bus and serves read misses with a slave read
// once every earlier write has gone out.

`timescale 1ns/10ps

module pi1_miss_control #(
	parameter int SET_COUNT = 8,
	parameter int BUF_DEPTH = 4
) (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  pi1_dcache_pkg::pi1_op_e m_op_i,
	input  pi1_dcache_pkg::addr_t   m_addr_i,
	input  pi1_dcache_pkg::word_t   m_data_i,
	input  pi1_dcache_pkg::sel_t    m_sel_i,
	output logic                    m_rdy_o,
	output pi1_dcache_pkg::word_t   m_data_o,
	input  logic                    hit_i,
	input  pi1_dcache_pkg::word_t   rd_data_i,
	input  logic                    sweeping_i,
	output pi1_dcache_pkg::addr_t   hold_addr_o,
	output pi1_dcache_pkg::sel_t    hold_sel_o,
	output pi1_dcache_pkg::word_t   hold_data_o,
	output logic                    lookup_o,
	output logic                    write_hit_o,
	output logic                    fill_o,
	output pi1_dcache_pkg::word_t   fill_data_o,
	output logic                    buf_push_o,
	output logic                    buf_pop_o,
	input  pi1_dcache_pkg::addr_t   buf_addr_i,
	input  pi1_dcache_pkg::word_t   buf_data_i,
	input  pi1_dcache_pkg::sel_t    buf_sel_i,
	input  logic                    buf_empty_i,
	input  logic                    buf_full_i,
	output pi1_dcache_pkg::pi1_op_e s_op_o,
	output pi1_dcache_pkg::addr_t   s_addr_o,
	output pi1_dcache_pkg::word_t   s_data_o,
	output pi1_dcache_pkg::sel_t    s_sel_o,
	input  pi1_dcache_pkg::word_t   s_data_i,
	input  logic                    s_rdy_i
);

	typedef enum logic [1:0] {
		IDLE,
		DRAIN_WAIT,
		READ_REQ,
		READ_WAIT
	} state_e;

	// Set indexing and buffer pointers both rely on power-of-2 sizes.
	if (SET_COUNT < 2 || (SET_COUNT & (SET_COUNT - 1)) != 0) begin : g_check_sets
		$error("SET_COUNT must be a power of 2 of at least 2");
	end
	if (BUF_DEPTH < 2 || (BUF_DEPTH & (BUF_DEPTH - 1)) != 0) begin : g_check_depth
		$error("BUF_DEPTH must be a power of 2 of at least 2");
	end

	state_e                  state_q;
	pi1_dcache_pkg::pi1_op_e op_q;
	pi1_dcache_pkg::addr_t   addr_q;
	pi1_dcache_pkg::word_t   data_q;
	pi1_dcache_pkg::sel_t    sel_q;
	pi1_dcache_pkg::word_t   fetch_q;
	logic                    eval_q;
	logic                    wr_out_q;
	logic                    use_fetch_q;

	logic                    accept;
	logic                    miss;
	logic                    wr_issue;
	logic                    rd_issue;
	logic                    rd_done;

	// The store answers one cycle after acceptance, which is the eval cycle.
	assign accept  = m_rdy_o && (m_op_i != pi1_dcache_pkg::OP_NOOP);
	assign miss    = eval_q && (op_q == pi1_dcache_pkg::OP_RD) && !hit_i;
	assign m_rdy_o = (state_q == IDLE) && !miss && !sweeping_i && !buf_full_i;

	assign lookup_o    = accept;
	assign write_hit_o = eval_q && (op_q == pi1_dcache_pkg::OP_WR) && hit_i;
	assign hold_addr_o = addr_q;
	assign hold_sel_o  = sel_q;
	assign hold_data_o = data_q;

	// Writes go to the buffer on acceptance, the master does not wait.
	assign buf_push_o = accept && (m_op_i == pi1_dcache_pkg::OP_WR);

	// No buffered write may pass a slave read that is waiting or in flight.
	assign wr_issue  = s_rdy_i && !buf_empty_i && (state_q == IDLE || state_q == DRAIN_WAIT);
	assign rd_issue  = s_rdy_i && (state_q == READ_REQ);
	assign rd_done   = s_rdy_i && (state_q == READ_WAIT);
	assign buf_pop_o = wr_issue;

	assign s_op_o   = rd_issue ? pi1_dcache_pkg::OP_RD :
	                  (wr_issue ? pi1_dcache_pkg::OP_WR : pi1_dcache_pkg::OP_NOOP);
	assign s_addr_o = (state_q == READ_REQ) ? addr_q : buf_addr_i;
	assign s_data_o = buf_data_i;
	// Misses always fetch the whole word.
	assign s_sel_o  = (state_q == READ_REQ) ? '1 : buf_sel_i;

	assign fill_o      = rd_done;
	assign fill_data_o = s_data_i;
	assign m_data_o    = use_fetch_q ? fetch_q : rd_data_i;

	always_ff @(posedge clk_i) begin
		if (accept) begin
			addr_q <= m_addr_i;
			data_q <= m_data_i;
			sel_q  <= m_sel_i;
		end
		if (rd_done)
			fetch_q <= s_data_i;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q     <= IDLE;
			op_q        <= pi1_dcache_pkg::OP_NOOP;
			eval_q      <= 1'b0;
			wr_out_q    <= 1'b0;
			use_fetch_q <= 1'b0;
		end else begin
			eval_q <= accept;
			if (accept)
				op_q <= m_op_i;
			// A slave write completes at the next edge with s_rdy_i high.
			if (s_rdy_i)
				wr_out_q <= wr_issue;
			if (accept)
				use_fetch_q <= 1'b0;
			else if (rd_done)
				use_fetch_q <= 1'b1;
			case (state_q)
				IDLE: begin
					if (miss)
						state_q <= DRAIN_WAIT;
				end
				DRAIN_WAIT: begin
					if (buf_empty_i && !wr_out_q)
						state_q <= READ_REQ;
				end
				READ_REQ: begin
					if (s_rdy_i)
						state_q <= READ_WAIT;
				end
				READ_WAIT: begin
					if (s_rdy_i)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

endmodule

/* logic/pi1_write_buffer.sv */
// PI1 data cache write buffer.
// Synchronous FIFO of the writes accepted from the master that still have
// to be issued on the slave bus. Entries leave in the order they came in.

`timescale 1ns/10ps

module pi1_write_buffer #(
	parameter int BUF_DEPTH = 4
) (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  push_i,
	input  pi1_dcache_pkg::addr_t addr_i,
	input  pi1_dcache_pkg::word_t data_i,
	input  pi1_dcache_pkg::sel_t  sel_i,
	input  logic                  pop_i,
	output pi1_dcache_pkg::addr_t addr_o,
	output pi1_dcache_pkg::word_t data_o,
	output pi1_dcache_pkg::sel_t  sel_o,
	output logic                  empty_o,
	output logic                  full_o
);

	localparam int PTR_BITS = $clog2(BUF_DEPTH);

	pi1_dcache_pkg::addr_t addr_mem [BUF_DEPTH];
	pi1_dcache_pkg::word_t data_mem [BUF_DEPTH];
	pi1_dcache_pkg::sel_t  sel_mem  [BUF_DEPTH];

	logic [PTR_BITS-1:0] wr_ptr_q;
	logic [PTR_BITS-1:0] rd_ptr_q;
	logic [PTR_BITS:0]   count_q;
	logic                do_push;
	logic                do_pop;

	// A push into a full buffer or a pop from an empty one has no effect.
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	assign empty_o = (count_q == '0);
	assign full_o  = (count_q == (PTR_BITS + 1)'(BUF_DEPTH));

	// The head entry is read straight from storage.
	assign addr_o = addr_mem[rd_ptr_q];
	assign data_o = data_mem[rd_ptr_q];
	assign sel_o  = sel_mem[rd_ptr_q];

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			addr_mem[wr_ptr_q] <= addr_i;
			data_mem[wr_ptr_q] <= data_i;
			sel_mem[wr_ptr_q]  <= sel_i;
		end
	end

	// Pointers wrap on their own since the depth is a power of 2.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_push && !do_pop)
				count_q <= count_q + 1'b1;
			else if (do_pop && !do_push)
				count_q <= count_q - 1'b1;
		end
	end

endmodule

/* pi1_dcache.f */
logic/pi1_dcache_pkg.sv
logic/pi1_write_buffer.sv
logic/pi1_cache_store.sv
logic/pi1_miss_control.sv
logic/pi1_dcache.sv
tb/pi1_dcache_properties.sv
tb/tb_pi1_dcache.sv

/* tb/pi1_dcache_properties.sv */
// PI1 data cache port properties.
// Checks the slave handshake, the reserved operation code, slave read
// selects and the valid sweep that holds off the master after reset and flush.

`timescale 1ns/10ps

module pi1_dcache_properties #(
	parameter int SET_COUNT = 8
) (
	input logic                    clk_i,
	input logic                    rst_i,
	input logic                    crst_i,
	input pi1_dcache_pkg::pi1_op_e m_op_i,
	input logic                    m_rdy_o,
	input pi1_dcache_pkg::pi1_op_e s_op_o,
	input pi1_dcache_pkg::sel_t    s_sel_o,
	input logic                    s_rdy_i
);

	int unsigned fail_count = 0;

	// No slave request may be issued while the slave stalls.
	a_stall_noop: assert property (@(posedge clk_i) disable iff (rst_i)
		!s_rdy_i |-> s_op_o == pi1_dcache_pkg::OP_NOOP)
	else begin
		$error("Slave request issued while the slave stalls");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge clk_i)
		rst_i |=> (s_op_o == pi1_dcache_pkg::OP_NOOP) && !m_rdy_o)
	else begin
		$error("Bus activity right after reset");
		fail_count++;
	end

	// The sweep keeps the master waiting for one cycle per set.
	a_reset_sweep: assert property (@(posedge clk_i)
		$fell(rst_i) |-> !m_rdy_o [*SET_COUNT])
	else begin
		$error("Master ready during the sweep after reset");
		fail_count++;
	end

	a_flush_sweep: assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(crst_i) |-> !m_rdy_o [*SET_COUNT])
	else begin
		$error("Master ready during the sweep after a flush");
		fail_count++;
	end

	a_flush_hold: assert property (@(posedge clk_i) crst_i |-> !m_rdy_o)
	else begin
		$error("Master ready while a flush is requested");
		fail_count++;
	end

	a_read_sel: assert property (@(posedge clk_i) disable iff (rst_i)
		s_op_o == pi1_dcache_pkg::OP_RD |-> s_sel_o == '1)
	else begin
		$error("Slave read without all byte selects");
		fail_count++;
	end

	a_no_reserved: assert property (@(posedge clk_i) disable iff (rst_i)
		m_op_i != 2'b11)
	else begin
		$error("Reserved operation code on the master bus");
		fail_count++;
	end

	a_known: assert property (@(posedge clk_i) disable iff (rst_i)
		!$isunknown(m_rdy_o) && !$isunknown(s_op_o))
	else begin
		$error("Unknown value on m_rdy_o or s_op_o");
		fail_count++;
	end

endmodule

bind pi1_dcache pi1_dcache_properties #(
	.SET_COUNT (SET_COUNT)
) u_props (
	.clk_i   (clk_i),
	.rst_i   (rst_i),
	.crst_i  (crst_i),
	.m_op_i  (m_op_i),
	.m_rdy_o (m_rdy_o),
	.s_op_o  (s_op_o),
	.s_sel_o (s_sel_o),
	.s_rdy_i (s_rdy_i)
);

/* tb/tb_pi1_dcache.sv */
// Testbench for the PI1 write-through data cache.
// Random master traffic runs against a slave memory with random latency.
// Read data is compared with a reference memory, slave writes with the
// master writes in issue order, and hit timing with a model of the lines.

`timescale 1ns/10ps

module tb_pi1_dcache;

	localparam int SET_COUNT  = 8;
	localparam int BUF_DEPTH  = 4;
	localparam int CLK_PERIOD = 4;
	localparam int ADDR_RANGE = 4 * SET_COUNT;
	localparam int RANGE_BITS = $clog2(ADDR_RANGE);
	localparam int RAND_OPS   = 300;
	localparam int TOTAL_OPS  = RAND_OPS + 3 * BUF_DEPTH + 8;

	logic                    clk_i = 1'b0;
	logic                    rst_i;
	logic                    crst_i;
	pi1_dcache_pkg::pi1_op_e m_op_i;
	pi1_dcache_pkg::addr_t   m_addr_i;
	pi1_dcache_pkg::word_t   m_data_i;
	pi1_dcache_pkg::sel_t    m_sel_i;
	pi1_dcache_pkg::word_t   m_data_o;
	logic                    m_rdy_o;
	pi1_dcache_pkg::pi1_op_e s_op_o;
	pi1_dcache_pkg::addr_t   s_addr_o;
	pi1_dcache_pkg::word_t   s_data_o;
	pi1_dcache_pkg::sel_t    s_sel_o;
	pi1_dcache_pkg::word_t   s_data_i;
	logic                    s_rdy_i;

	logic [31:0]             lfsr_q;
	logic                    long_stalls;
	pi1_dcache_pkg::word_t   ref_mem   [ADDR_RANGE];
	pi1_dcache_pkg::word_t   slave_mem [ADDR_RANGE];
	pi1_dcache_pkg::addr_t   line_addr [SET_COUNT];
	logic                    line_valid [SET_COUNT];
	pi1_dcache_pkg::addr_t   wq_addr [$];
	pi1_dcache_pkg::word_t   wq_data [$];
	pi1_dcache_pkg::sel_t    wq_sel  [$];
	logic                    rd_pending;
	logic                    rd_hit;
	logic                    rd_waited;
	pi1_dcache_pkg::addr_t   rd_addr;
	pi1_dcache_pkg::word_t   rd_exp;
	int                      rd_fetches;
	logic                    slv_busy;
	pi1_dcache_pkg::addr_t   slv_addr;

	pi1_dcache #(
		.SET_COUNT (SET_COUNT),
		.BUF_DEPTH (BUF_DEPTH)
	) u_pi1_dcache (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.crst_i   (crst_i),
		.m_op_i   (m_op_i),
		.m_addr_i (m_addr_i),
		.m_data_i (m_data_i),
		.m_sel_i  (m_sel_i),
		.m_data_o (m_data_o),
		.m_rdy_o  (m_rdy_o),
		.s_op_o   (s_op_o),
		.s_addr_o (s_addr_o),
		.s_data_o (s_data_o),
		.s_sel_o  (s_sel_o),
		.s_data_i (s_data_i),
		.s_rdy_i  (s_rdy_i)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// Fibonacci LFSR with the polynomial x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic pi1_dcache_pkg::word_t merge_bytes(input pi1_dcache_pkg::word_t old_w,
			input pi1_dcache_pkg::word_t new_w, input pi1_dcache_pkg::sel_t sel);
		pi1_dcache_pkg::word_t w;
		w = old_w;
		for (int b = 0; b < pi1_dcache_pkg::SEL_BITS; b++)
			if (sel[b])
				w[8*b +: 8] = new_w[8*b +: 8];
		return w;
	endfunction

	function automatic pi1_dcache_pkg::word_t init_word(input int a);
		return {8'h5a, 8'(a), 8'(~a), 8'(a * 7)};
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else fail_run($sformatf("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
			$time, name, got, exp));
	endtask

	// The slave stalls at random and presents read data while a read is open.
	task automatic drive_slave();
		if (long_stalls)
			s_rdy_i = (take_bits(3) == 0);
		else
			s_rdy_i = (take_bits(2) != 0);
		s_data_i = slv_busy ? slave_mem[slv_addr[RANGE_BITS-1:0]] : take_bits(32);
	endtask

	// Models what the coming rising edge does on both buses.
	task automatic model_edge(output logic accepted);
		int idx;
		int set_idx;
		accepted = 1'b0;
		if (wq_addr.size() == BUF_DEPTH)
			check_value("m_rdy_o", m_rdy_o, 1'b0);
		if (s_rdy_i) begin
			slv_busy = 1'b0;
			if (s_op_o == pi1_dcache_pkg::OP_WR) begin
				assert (wq_addr.size() != 0)
				else fail_run("The DUT issued a slave write that no master write asked for");
				check_value("s_addr_o", s_addr_o, wq_addr.pop_front());
				check_value("s_data_o", s_data_o, wq_data.pop_front());
				check_value("s_sel_o", s_sel_o, wq_sel.pop_front());
				idx = int'(s_addr_o[RANGE_BITS-1:0]);
				slave_mem[idx] = merge_bytes(slave_mem[idx], s_data_o, s_sel_o);
			end else if (s_op_o == pi1_dcache_pkg::OP_RD) begin
				assert (rd_pending && !rd_hit && rd_fetches == 0)
				else fail_run("The DUT issued a slave read that no read miss asked for");
				check_value("s_addr_o", s_addr_o, rd_addr);
				rd_fetches++;
				slv_busy = 1'b1;
				slv_addr = s_addr_o;
			end
		end
		if (rd_pending) begin
			// A hit answers in the first cycle after acceptance.
			if (rd_hit && !rd_waited)
				check_value("m_rdy_o", m_rdy_o, 1'b1);
			if (m_rdy_o) begin
				check_value("m_data_o", m_data_o, rd_exp);
				check_value("slave reads", rd_fetches, rd_hit ? 0 : 1);
				set_idx = int'(rd_addr) % SET_COUNT;
				line_valid[set_idx] = 1'b1;
				line_addr[set_idx] = rd_addr;
				rd_pending = 1'b0;
			end
			rd_waited = 1'b1;
		end
		if (m_rdy_o && m_op_i != pi1_dcache_pkg::OP_NOOP) begin
			accepted = 1'b1;
			idx = int'(m_addr_i[RANGE_BITS-1:0]);
			set_idx = int'(m_addr_i) % SET_COUNT;
			if (m_op_i == pi1_dcache_pkg::OP_WR) begin
				ref_mem[idx] = merge_bytes(ref_mem[idx], m_data_i, m_sel_i);
				wq_addr.push_back(m_addr_i);
				wq_data.push_back(m_data_i);
				wq_sel.push_back(m_sel_i);
			end else begin
				rd_pending = 1'b1;
				rd_addr = m_addr_i;
				rd_exp = ref_mem[idx];
				rd_hit = line_valid[set_idx] && (line_addr[set_idx] == m_addr_i);
				rd_fetches = 0;
				rd_waited = 1'b0;
			end
		end
	endtask

	// Inputs change on the falling edge and are sampled 1 ns later.
	task automatic step_cycle(output logic accepted);
		#1;
		model_edge(accepted);
		@(negedge clk_i);
		drive_slave();
	endtask

	task automatic issue_op(input pi1_dcache_pkg::pi1_op_e op, input pi1_dcache_pkg::addr_t addr,
			input pi1_dcache_pkg::word_t data, input pi1_dcache_pkg::sel_t sel);
		logic accepted;
		m_op_i = op;
		m_addr_i = addr;
		m_data_i = data;
		m_sel_i = sel;
		do
			step_cycle(accepted);
		while (!accepted);
		m_op_i = pi1_dcache_pkg::OP_NOOP;
	endtask

	task automatic random_op(input logic write_only);
		pi1_dcache_pkg::pi1_op_e op;
		pi1_dcache_pkg::addr_t   addr;
		pi1_dcache_pkg::word_t   data;
		pi1_dcache_pkg::sel_t    sel;
		if (write_only || take_bits(1))
			op = pi1_dcache_pkg::OP_WR;
		else
			op = pi1_dcache_pkg::OP_RD;
		addr = pi1_dcache_pkg::addr_t'(take_bits(RANGE_BITS));
		data = take_bits(32);
		sel = pi1_dcache_pkg::sel_t'(take_bits(pi1_dcache_pkg::SEL_BITS));
		issue_op(op, addr, data, sel);
	endtask

	// Flush once the last read has returned, then forget every line.
	task automatic flush_cache();
		logic accepted;
		while (rd_pending)
			step_cycle(accepted);
		step_cycle(accepted);
		crst_i = 1'b1;
		step_cycle(accepted);
		crst_i = 1'b0;
		for (int s = 0; s < SET_COUNT; s++)
			line_valid[s] = 1'b0;
	endtask

	always @(negedge clk_i) begin
		if (u_pi1_dcache.u_props.fail_count != 0)
			fail_run("A port property of the DUT was violated");
	end

	initial begin
		#(TOTAL_OPS * 200 * CLK_PERIOD);
		fail_run("Timeout: the test did not complete within its cycle budget");
	end

	initial begin
		logic accepted;
		lfsr_q = 32'd78266;
		rst_i = 1'b1;
		crst_i = 1'b0;
		m_op_i = pi1_dcache_pkg::OP_NOOP;
		m_addr_i = '0;
		m_data_i = '0;
		m_sel_i = '0;
		s_rdy_i = 1'b1;
		s_data_i = '0;
		long_stalls = 1'b0;
		rd_pending = 1'b0;
		slv_busy = 1'b0;
		for (int a = 0; a < ADDR_RANGE; a++) begin
			ref_mem[a] = init_word(a);
			slave_mem[a] = init_word(a);
		end
		for (int s = 0; s < SET_COUNT; s++)
			line_valid[s] = 1'b0;
		repeat (10) @(negedge clk_i);
		rst_i = 1'b0;

		// Miss, hit, then a merged write read back through the bypass.
		issue_op(pi1_dcache_pkg::OP_RD, 5, '0, '0);
		issue_op(pi1_dcache_pkg::OP_RD, 5, '0, '0);
		issue_op(pi1_dcache_pkg::OP_WR, 5, 32'hdead_beef, 4'b0101);
		issue_op(pi1_dcache_pkg::OP_RD, 5, '0, '0);

		for (int i = 0; i < RAND_OPS; i++) begin
			random_op(1'b0);
			if (take_bits(3) == 0)
				step_cycle(accepted);
		end

		// A cached address has to be fetched again after the flush.
		issue_op(pi1_dcache_pkg::OP_RD, 9, '0, '0);
		flush_cache();
		issue_op(pi1_dcache_pkg::OP_RD, 9, '0, '0);

		// Long slave stalls fill the write buffer.
		long_stalls = 1'b1;
		for (int i = 0; i < 3 * BUF_DEPTH; i++)
			random_op(1'b1);
		issue_op(pi1_dcache_pkg::OP_RD, 9, '0, '0);
		long_stalls = 1'b0;

		while (rd_pending || slv_busy || wq_addr.size() != 0)
			step_cycle(accepted);
		step_cycle(accepted);

		if (u_pi1_dcache.u_props.fail_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			fail_run("A port property failed during the run");
		end
	end

endmodule
